/* glay_mem_pkg.sv */
// Vertex property store package with memory geometry, vector types and port structs
package glay_mem_pkg;

	// ------------------------------------------------------------
	// Memory geometry
	// ------------------------------------------------------------

	// One vertex property word
	localparam int DATA_W      = 32;
	// Width of one write lane
	localparam int BYTE_W      = 8;
	// Byte lanes per word
	localparam int NUM_LANES   = DATA_W / BYTE_W;
	// Logical word address, 2048 words
	localparam int ADDR_W      = 11;
	localparam int MEM_DEPTH   = 2 ** ADDR_W;
	// Words held by one physical RAM block
	localparam int BLOCK_DEPTH = 1024;

	// ------------------------------------------------------------
	// Vector types
	// ------------------------------------------------------------

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [NUM_LANES-1:0] lane_t;

	// ------------------------------------------------------------
	// Port structs
	// ------------------------------------------------------------

	// Request into the store
	// we all zero means read
	typedef struct packed {
		logic  en;
		lane_t we;
		addr_t addr;
		data_t din;
	} mem_req_t;

	// Response out of the store
	// data is zero unless valid
	typedef struct packed {
		logic  valid;
		data_t data;
	} mem_rsp_t;

endpackage : glay_mem_pkg

/* spram_bank.sv */
// Single-port RAM block with byte-lane writes and a one-cycle registered read
module spram_bank #(
	parameter int BANK_ADDR_W = 10
) (
	input  logic                ap_clk,
	input  logic                rsta,
	input  logic                en,
	input  glay_mem_pkg::lane_t we,
	input  logic [BANK_ADDR_W-1:0] addr,
	input  glay_mem_pkg::data_t din,
	output glay_mem_pkg::data_t dout
);

	// Words in this block
	localparam int DEPTH = 2 ** BANK_ADDR_W;

	// Storage array, starts at zero
	glay_mem_pkg::data_t mem [DEPTH] = '{default: '0};

	// ------------------------------------------------------------
	// Write port
	// ------------------------------------------------------------

	// One byte per set lane
	// Lanes left clear keep their old byte
	always_ff @(posedge ap_clk) begin
		if (en) begin
			for (int i = 0; i < glay_mem_pkg::NUM_LANES; i++) begin
				if (we[i]) begin
					mem[addr][i*glay_mem_pkg::BYTE_W +: glay_mem_pkg::BYTE_W] <=
						din[i*glay_mem_pkg::BYTE_W +: glay_mem_pkg::BYTE_W];
				end
			end
		end
	end

	// ------------------------------------------------------------
	// Read port
	// ------------------------------------------------------------

	// Read-first, a write cycle returns the old word
	// Holds its value on idle cycles
	always_ff @(posedge ap_clk) begin
		if (rsta) begin
			dout <= '0;
		end else if (en) begin
			dout <= mem[addr];
		end
	end

endmodule : spram_bank

/* spram_split.sv */
// Logical memory built from one RAM block or two half-depth blocks split on the top address bit
module spram_split (
	input  logic                ap_clk,
	input  logic                rsta,
	input  logic                en,
	input  glay_mem_pkg::lane_t we,
	input  glay_mem_pkg::addr_t addr,
	input  glay_mem_pkg::data_t din,
	output glay_mem_pkg::data_t dout
);

	// Steered enable per bank, bit 1 unused with a single bank
	logic [1:0] bank_en;
	// Bank enables one cycle back, line up with bank dout
	logic [1:0] bank_en_q;
	// Read word of each bank
	glay_mem_pkg::data_t bank_dout [2];

	generate
		if (glay_mem_pkg::MEM_DEPTH > glay_mem_pkg::BLOCK_DEPTH) begin : g_split

			// ------------------------------------------------------------
			// Two half-depth banks
			// ------------------------------------------------------------

			localparam int HALF_W = glay_mem_pkg::ADDR_W - 1;

			glay_mem_pkg::lane_t bank_we   [2];
			logic [HALF_W-1:0]   bank_addr [2];
			glay_mem_pkg::data_t bank_din  [2];

			// Top bit picks the bank
			// The idle bank sees all strobes at zero
			always_comb begin
				for (int b = 0; b < 2; b++) begin
					if (addr[glay_mem_pkg::ADDR_W-1] == b[0]) begin
						bank_en[b]   = en;
						bank_we[b]   = we;
						bank_addr[b] = addr[HALF_W-1:0];
						bank_din[b]  = din;
					end else begin
						bank_en[b]   = 1'b0;
						bank_we[b]   = '0;
						bank_addr[b] = '0;
						bank_din[b]  = '0;
					end
				end
			end

			for (genvar b = 0; b < 2; b++) begin : g_bank
				spram_bank #(
					.BANK_ADDR_W(HALF_W)
				) u_bank (
					.ap_clk(ap_clk),
					.rsta  (rsta),
					.en    (bank_en[b]),
					.we    (bank_we[b]),
					.addr  (bank_addr[b]),
					.din   (bank_din[b]),
					.dout  (bank_dout[b])
				);
			end

		end else begin : g_single

			// ------------------------------------------------------------
			// Fits in one bank
			// ------------------------------------------------------------

			assign bank_en      = {1'b0, en};
			assign bank_dout[1] = '0;

			spram_bank #(
				.BANK_ADDR_W(glay_mem_pkg::ADDR_W)
			) u_bank (
				.ap_clk(ap_clk),
				.rsta  (rsta),
				.en    (bank_en[0]),
				.we    (we),
				.addr  (addr),
				.din   (din),
				.dout  (bank_dout[0])
			);

		end
	endgenerate

	// Remember which bank ran this cycle
	always_ff @(posedge ap_clk) begin
		if (rsta) begin
			bank_en_q <= '0;
		end else begin
			bank_en_q <= bank_en;
		end
	end

	// Return mux, zero after an idle cycle
	always_comb begin
		if (bank_en_q[0]) begin
			dout = bank_dout[0];
		end else if (bank_en_q[1]) begin
			dout = bank_dout[1];
		end else begin
			dout = '0;
		end
	end

endmodule : spram_split

/* mem_port.sv */
// Request/response port stage with input register and read-valid tracking
module mem_port (
	input  logic                   ap_clk,
	input  logic                   rsta,
	input  glay_mem_pkg::mem_req_t req,
	output glay_mem_pkg::mem_rsp_t rsp,
	output logic                   mem_en,
	output glay_mem_pkg::lane_t    mem_we,
	output glay_mem_pkg::addr_t    mem_addr,
	output glay_mem_pkg::data_t    mem_din,
	input  glay_mem_pkg::data_t    mem_dout
);

	// Registered request, drives the memory strobes
	glay_mem_pkg::mem_req_t req_q;
	// Read issued to memory last cycle
	logic rd_q;

	// ------------------------------------------------------------
	// Request register
	// ------------------------------------------------------------

	always_ff @(posedge ap_clk) begin
		if (rsta) begin
			req_q <= '0;
		end else begin
			req_q <= req;
		end
	end

	assign mem_en   = req_q.en;
	assign mem_we   = req_q.we;
	assign mem_addr = req_q.addr;
	assign mem_din  = req_q.din;

	// ------------------------------------------------------------
	// Read tracking
	// ------------------------------------------------------------

	// Enabled with no lanes set means read
	// Delayed to match the one-cycle memory latency
	always_ff @(posedge ap_clk) begin
		if (rsta) begin
			rd_q <= 1'b0;
		end else begin
			rd_q <= req_q.en && (req_q.we == '0);
		end
	end

	// Writes also return a word from the bank, masked here
	always_comb begin
		rsp.valid = rd_q;
		rsp.data  = rd_q ? mem_dout : '0;
	end

endmodule : mem_port

/* vertex_store_top.sv */
// Vertex property store top joining the port stage to the banked memory
module vertex_store_top (
	input  logic                   ap_clk,
	input  logic                   rsta,
	input  glay_mem_pkg::mem_req_t req,
	output glay_mem_pkg::mem_rsp_t rsp
);

	// Raw memory strobes between port and RAM
	logic                mem_en;
	glay_mem_pkg::lane_t mem_we;
	glay_mem_pkg::addr_t mem_addr;
	glay_mem_pkg::data_t mem_din;
	glay_mem_pkg::data_t mem_dout;

	mem_port u_port (
		.ap_clk  (ap_clk),
		.rsta    (rsta),
		.req     (req),
		.rsp     (rsp),
		.mem_en  (mem_en),
		.mem_we  (mem_we),
		.mem_addr(mem_addr),
		.mem_din (mem_din),
		.mem_dout(mem_dout)
	);

	// Two banks at the default 2048-word depth
	spram_split u_mem (
		.ap_clk(ap_clk),
		.rsta  (rsta),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.din   (mem_din),
		.dout  (mem_dout)
	);

endmodule : vertex_store_top

/* tb_clock_gen.sv */
// Testbench clock and power-on reset source for the vertex property store
module tb_clock_gen (
	output logic ap_clk,
	output logic rsta
);

	// Clock period in time units
	localparam int PERIOD       = 100;
	// Rising edges seen with reset held
	localparam int RESET_CYCLES = 2;

	initial begin
		ap_clk = 1'b0;
		forever begin
			#(PERIOD / 2) ap_clk = ~ap_clk;
		end
	end

	// Released on a rising edge, matches the synchronous reset it feeds
	initial begin
		rsta = 1'b1;
		repeat (RESET_CYCLES) @(posedge ap_clk);
		rsta <= 1'b0;
	end

endmodule : tb_clock_gen

/* vertex_store_asserts.sv */
// Bank steering, idle return and reset quiet assertions for the split memory
module vertex_store_asserts (
	input logic                ap_clk,
	input logic                rsta,
	input logic                en,
	input glay_mem_pkg::lane_t we,
	input logic [1:0]          bank_en,
	input glay_mem_pkg::data_t dout
);

	// ------------------------------------------------------------
	// Bank steering
	// ------------------------------------------------------------

	// Only one half-depth bank runs per access
	bank_exclusive_a: assert property (@(posedge ap_clk) !(bank_en[0] && bank_en[1]))
		else $error("both bank enables high in the same cycle");

	// ------------------------------------------------------------
	// Response timing
	// ------------------------------------------------------------

	// Idle cycle leaves the return mux at zero one cycle later
	idle_dout_zero_a: assert property (@(posedge ap_clk) disable iff (rsta)
		!en |=> dout == '0)
		else $error("dout not zero after a cycle with no enable");

	// Strobes held off once reset has been high for a full cycle
	reset_quiet_a: assert property (@(posedge ap_clk)
		rsta && $past(rsta) |-> !en && we == '0)
		else $error("memory strobes active during reset");

endmodule : vertex_store_asserts

// Attached to every split memory instance
bind spram_split vertex_store_asserts u_asserts (
	.ap_clk (ap_clk),
	.rsta   (rsta),
	.en     (en),
	.we     (we),
	.bank_en(bank_en),
	.dout   (dout)
);

/* vertex_store_tb.sv */
// Vertex property store testbench with a stimulus table, reference model and response checks
module vertex_store_tb;

	// Edges from request acceptance to the returned word
	localparam int RSP_LATENCY = 2;
	localparam int RESET_LIMIT = 10;
	localparam int DRAIN_LIMIT = 20;
	localparam int RAND_ROWS   = 48;

	// One read in flight
	// due is the cycle count where rsp.valid must show
	typedef struct packed {
		glay_mem_pkg::addr_t addr;
		glay_mem_pkg::data_t data;
		int                  due;
	} exp_t;

	logic                   ap_clk;
	logic                   rsta;
	glay_mem_pkg::mem_req_t req;
	glay_mem_pkg::mem_rsp_t rsp;

	// Stimulus table with one row per cycle
	glay_mem_pkg::mem_req_t stim_req [$];
	string                  stim_name[$];

	// Reference model and reads in flight
	glay_mem_pkg::data_t ref_mem [glay_mem_pkg::MEM_DEPTH];
	exp_t                exp_q   [$];
	string               exp_name[$];
	int                  cyc = 0;

	tb_clock_gen u_clk (
		.ap_clk(ap_clk),
		.rsta  (rsta)
	);

	vertex_store_top DUT (
		.ap_clk(ap_clk),
		.rsta  (rsta),
		.req   (req),
		.rsp   (rsp)
	);

	always @(posedge ap_clk) begin
		cyc <= cyc + 1;
	end

	// ------------------------------------------------------------
	// Error handling and compares
	// ------------------------------------------------------------

	task automatic stop_on_error();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare_data(string name, glay_mem_pkg::data_t exp,
			glay_mem_pkg::data_t act);
		if (act !== exp) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic compare_valid(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("ERROR %s valid expected %b actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	// ------------------------------------------------------------
	// Table building
	// ------------------------------------------------------------

	task automatic add_row(string name, logic en, glay_mem_pkg::lane_t we,
			glay_mem_pkg::addr_t addr, glay_mem_pkg::data_t din);
		glay_mem_pkg::mem_req_t r;
		r.en   = en;
		r.we   = we;
		r.addr = addr;
		r.din  = din;
		stim_req.push_back(r);
		stim_name.push_back(name);
	endtask

	task automatic add_write(string name, glay_mem_pkg::lane_t we,
			glay_mem_pkg::addr_t addr, glay_mem_pkg::data_t din);
		add_row(name, 1'b1, we, addr, din);
	endtask

	task automatic add_read(string name, glay_mem_pkg::addr_t addr);
		add_row(name, 1'b1, '0, addr, '0);
	endtask

	task automatic build_table();
		glay_mem_pkg::lane_t we;
		glay_mem_pkg::addr_t addr;
		// Quiet port after reset
		for (int i = 0; i < 4; i++) begin
			add_row("idle_after_reset", 1'b0, '0, '0, '0);
		end
		// Full words in both halves around the bank boundary
		add_write("wr_lo_0", 4'hf, 11'd0, 32'h0000_a001);
		add_write("wr_lo_5", 4'hf, 11'd5, 32'h0505_0505);
		add_write("wr_lo_1023", 4'hf, 11'd1023, 32'hdead_03ff);
		add_write("wr_hi_1024", 4'hf, 11'd1024, 32'hbeef_0400);
		add_write("wr_hi_1029", 4'hf, 11'd1029, 32'hcafe_0405);
		add_write("wr_hi_2047", 4'hf, 11'd2047, 32'hfeed_07ff);
		add_write("wr_lo_7", 4'hf, 11'd7, 32'h7777_0007);
		add_read("rd_lo_0", 11'd0);
		add_row("gap", 1'b0, '0, '0, '0);
		add_read("rd_hi_1024", 11'd1024);
		add_read("rd_hi_1031_untouched", 11'd1031);
		add_read("rd_lo_7", 11'd7);
		// Byte lanes merge into the old word
		add_write("part_base", 4'hf, 11'h200, 32'h1122_3344);
		add_write("part_lanes_0_2", 4'b0101, 11'h200, 32'haabb_ccdd);
		add_read("part_rd_0_2", 11'h200);
		add_write("part_lane_3", 4'b1000, 11'h200, 32'h99ff_ffff);
		add_read("part_rd_3", 11'h200);
		add_write("part_hi_lane_1", 4'b0010, 11'h600, 32'h0000_5a00);
		add_read("part_rd_hi", 11'h600);
		// Back to back, alternating banks
		add_read("b2b_lo_5", 11'd5);
		add_read("b2b_hi_1029", 11'd1029);
		add_read("b2b_lo_1023", 11'd1023);
		add_read("b2b_hi_2047", 11'd2047);
		add_read("b2b_lo_0", 11'd0);
		add_read("b2b_hi_1024", 11'd1024);
		// Read right behind a write to the same word
		add_write("wr_then_rd_lo", 4'hf, 11'h123, 32'h0123_4567);
		add_read("rd_after_wr_lo", 11'h123);
		add_write("wr_then_rd_hi", 4'hf, 11'h523, 32'h89ab_cdef);
		add_read("rd_after_wr_hi", 11'h523);
		// Random mix on a small address pool in both banks
		for (int i = 0; i < RAND_ROWS; i++) begin
			addr = glay_mem_pkg::addr_t'($urandom) & 11'h40f;
			we   = ($urandom % 2 == 0) ? '0 : glay_mem_pkg::lane_t'($urandom);
			add_row($sformatf("random_%0d", i), ($urandom % 8) != 0, we, addr, $urandom);
		end
	endtask

	// ------------------------------------------------------------
	// Reference model and response monitor
	// ------------------------------------------------------------

	// Writes merge set lanes and reads queue the word they must see
	task automatic model_request(string name, glay_mem_pkg::mem_req_t r);
		exp_t e;
		if (r.en && r.we != '0) begin
			for (int i = 0; i < glay_mem_pkg::NUM_LANES; i++) begin
				if (r.we[i]) begin
					ref_mem[r.addr][i*glay_mem_pkg::BYTE_W +: glay_mem_pkg::BYTE_W] =
						r.din[i*glay_mem_pkg::BYTE_W +: glay_mem_pkg::BYTE_W];
				end
			end
		end else if (r.en) begin
			e.addr = r.addr;
			e.data = ref_mem[r.addr];
			// One edge to acceptance and then the fixed latency
			e.due  = cyc + 1 + RSP_LATENCY;
			exp_q.push_back(e);
			exp_name.push_back(name);
		end
	endtask

	task automatic check_response();
		exp_t  e;
		string name;
		if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
			e    = exp_q.pop_front();
			name = $sformatf("%s addr %0d", exp_name.pop_front(), e.addr);
			compare_valid(name, 1'b1, rsp.valid);
			compare_data(name, e.data, rsp.data);
		end else begin
			compare_valid("no_read_due", 1'b0, rsp.valid);
			compare_data("no_read_due", '0, rsp.data);
		end
	endtask

	// Checked on the falling edge where rsp has settled
	always @(negedge ap_clk) begin
		if (!rsta) begin
			check_response();
		end
	end

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------

	initial begin
		int waited;
		// A write held on the port through reset must never reach a bank
		req      = '0;
		req.en   = 1'b1;
		req.we   = '1;
		req.addr = 11'd1031;
		req.din  = 32'hbad0_0407;
		void'($urandom(32'ha3b9));
		foreach (ref_mem[i]) begin
			ref_mem[i] = '0;
		end
		build_table();
		waited = 0;
		@(posedge ap_clk);
		while (rsta) begin
			if (waited > RESET_LIMIT) begin
				$display("Timeout: reset was never released");
				stop_on_error();
			end
			// Port goes quiet before reset is released
			req <= '0;
			@(posedge ap_clk);
			waited++;
		end
		foreach (stim_req[i]) begin
			req <= stim_req[i];
			model_request(stim_name[i], stim_req[i]);
			@(posedge ap_clk);
		end
		req <= '0;
		waited = 0;
		while (exp_q.size() != 0) begin
			if (waited > DRAIN_LIMIT) begin
				$display("Timeout: reads still waiting for a response at the end");
				stop_on_error();
			end
			@(negedge ap_clk);
			waited++;
		end
		$display("Test OK");
		$finish;
	end

endmodule : vertex_store_tb

/* list.f */
glay_mem_pkg.sv
spram_bank.sv
spram_split.sv
mem_port.sv
vertex_store_top.sv
tb_clock_gen.sv
vertex_store_asserts.sv
vertex_store_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = vertex_store_tb
FILELIST  = list.f
OBJDIR    = obj_dir

.PHONY: sim clean

# Build and run, exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
